// ==== design/exe_pkg.sv ====
// Shared widths, instruction classes and funct3 codes
// for the RV64I execute stage.

package exe_pkg;

  // ==============================
  // Widths
  // ==============================
  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [2:0]  funct3_t;

  // Decoded instruction class.
  typedef enum logic [3:0] {
    OP        = 4'd0,
    OP_IMM    = 4'd1,
    OP_32     = 4'd2,
    OP_IMM_32 = 4'd3,
    LUI       = 4'd4,
    AUIPC     = 4'd5,
    JAL       = 4'd6,
    JALR      = 4'd7,
    BRANCH    = 4'd8,
    LOAD      = 4'd9,
    STORE     = 4'd10
  } op_class_t;

  // ==============================
  // funct3 codes
  // ==============================
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  // Sequential PC step.
  localparam xlen_t INST_BYTES = 64'd4;

  // Shift amount width for 64-bit shifts.
  localparam int SHAMT_W = 6;

endpackage

// ==== design/exe_op_if.sv ====
// Held instruction bundle from the stage register
// to the ALU and branch units.

`timescale 1ns/1ns

interface exe_op_if;

  logic                ena;
  exe_pkg::op_class_t  op_class;
  exe_pkg::funct3_t    funct3;
  // funct7 bit 5, selects SUB and SRA.
  logic                alt;
  exe_pkg::xlen_t      pc;
  exe_pkg::xlen_t      op1;
  exe_pkg::xlen_t      op2;
  exe_pkg::xlen_t      imm;

  modport stage (
    output ena,
    output op_class,
    output funct3,
    output alt,
    output pc,
    output op1,
    output op2,
    output imm
  );

  modport alu (
    input  ena,
    input  op_class,
    input  funct3,
    input  alt,
    input  pc,
    input  op1,
    input  op2,
    input  imm
  );

  modport branch (
    input  ena,
    input  op_class,
    input  funct3,
    input  alt,
    input  pc,
    input  op1,
    input  op2,
    input  imm
  );

endinterface

// ==== design/exe_stage.sv ====
// Execute stage register with decoded and executed handshakes.

`timescale 1ns/1ns

module exe_stage (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_dec_req,
  output logic                o_dec_ack,
  output logic                o_exe_req,
  input  logic                i_exe_ack,
  input  exe_pkg::op_class_t  i_op_class,
  input  exe_pkg::funct3_t    i_funct3,
  input  logic                i_alt,
  input  exe_pkg::xlen_t      i_pc,
  input  exe_pkg::inst_t      i_inst,
  input  exe_pkg::xlen_t      i_op1,
  input  exe_pkg::xlen_t      i_op2,
  input  exe_pkg::xlen_t      i_imm,
  input  exe_pkg::xlen_t      i_pc_pred,
  input  exe_pkg::reg_idx_t   i_rd,
  input  logic                i_rd_wen,
  output exe_pkg::xlen_t      o_pc,
  output exe_pkg::inst_t      o_inst,
  output exe_pkg::funct3_t    o_funct3,
  output exe_pkg::reg_idx_t   o_rd,
  output logic                o_rd_wen_req,
  output exe_pkg::xlen_t      o_pc_pred,
  exe_op_if.stage             op
);

  logic                valid;
  logic                dec_hs;
  logic                exe_hs;

  exe_pkg::op_class_t  hold_op_class;
  exe_pkg::funct3_t    hold_funct3;
  logic                hold_alt;
  exe_pkg::xlen_t      hold_pc;
  exe_pkg::inst_t      hold_inst;
  exe_pkg::xlen_t      hold_op1;
  exe_pkg::xlen_t      hold_op2;
  exe_pkg::xlen_t      hold_imm;
  exe_pkg::xlen_t      hold_pc_pred;
  exe_pkg::reg_idx_t   hold_rd;
  logic                hold_rd_wen;

  // ==============================
  // Handshakes
  // ==============================
  // Accept when empty or when the held result leaves this cycle.
  assign o_exe_req = valid;
  assign exe_hs    = valid && i_exe_ack;
  assign o_dec_ack = !valid || exe_hs;
  assign dec_hs    = i_dec_req && o_dec_ack;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid <= 1'b0;
    end else if (dec_hs) begin
      valid <= 1'b1;
    end else if (exe_hs) begin
      valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_hs) begin
      hold_op_class <= i_op_class;
      hold_funct3   <= i_funct3;
      hold_alt      <= i_alt;
      hold_pc       <= i_pc;
      hold_inst     <= i_inst;
      hold_op1      <= i_op1;
      hold_op2      <= i_op2;
      hold_imm      <= i_imm;
      hold_pc_pred  <= i_pc_pred;
      hold_rd       <= i_rd;
      hold_rd_wen   <= i_rd_wen;
    end
  end

  // ==============================
  // Outputs, zero while empty
  // ==============================
  assign o_pc         = valid ? hold_pc      : '0;
  assign o_inst       = valid ? hold_inst    : '0;
  assign o_funct3     = valid ? hold_funct3  : '0;
  assign o_rd         = valid ? hold_rd      : '0;
  assign o_rd_wen_req = valid && hold_rd_wen;
  assign o_pc_pred    = valid ? hold_pc_pred : '0;

  assign op.ena      = valid;
  assign op.op_class = valid ? hold_op_class : exe_pkg::OP;
  assign op.funct3   = valid ? hold_funct3   : '0;
  assign op.alt      = valid && hold_alt;
  assign op.pc       = valid ? hold_pc       : '0;
  assign op.op1      = valid ? hold_op1      : '0;
  assign op.op2      = valid ? hold_op2      : '0;
  assign op.imm      = valid ? hold_imm      : '0;

  // Request holds until taken.
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    o_exe_req && !i_exe_ack |=> o_exe_req);

  // Held instruction stays put under back-pressure.
  a_pc_hold: assert property (@(posedge clk) disable iff (rst)
    o_exe_req && !i_exe_ack |=> $stable(o_pc));

endmodule

// ==== design/exe_alu.sv ====
// Integer result, write enable and load/store address
// for the held instruction.

`timescale 1ns/1ns

module exe_alu (
  exe_op_if.alu           op,
  input  logic            i_rd_wen_req,
  output logic            o_rd_wen,
  output exe_pkg::xlen_t  o_rd_wdata,
  output exe_pkg::xlen_t  o_memaddr,
  output logic            o_memren,
  output logic            o_memwen
);

  logic [exe_pkg::SHAMT_W-1:0]  shamt;
  logic [4:0]                   shamt_w;
  logic                         sub;
  exe_pkg::xlen_t               res64;
  logic [31:0]                  res32;
  logic                         is_load;
  logic                         is_store;

  assign shamt   = op.op2[exe_pkg::SHAMT_W-1:0];
  assign shamt_w = op.op2[4:0];

  // No SUBI, so alt only subtracts on register forms.
  assign sub = op.alt &&
               (op.op_class == exe_pkg::OP || op.op_class == exe_pkg::OP_32);

  // ==============================
  // 64-bit operations
  // ==============================
  always_comb begin
    case (op.funct3)
      exe_pkg::F3_ADD:  res64 = sub ? op.op1 - op.op2 : op.op1 + op.op2;
      exe_pkg::F3_SLL:  res64 = op.op1 << shamt;
      exe_pkg::F3_SLT:  res64 = {63'd0, $signed(op.op1) < $signed(op.op2)};
      exe_pkg::F3_SLTU: res64 = {63'd0, op.op1 < op.op2};
      exe_pkg::F3_XOR:  res64 = op.op1 ^ op.op2;
      exe_pkg::F3_SR: begin
        if (op.alt) begin
          res64 = $signed(op.op1) >>> shamt;
        end else begin
          res64 = op.op1 >> shamt;
        end
      end
      exe_pkg::F3_OR:   res64 = op.op1 | op.op2;
      default:          res64 = op.op1 & op.op2;
    endcase
  end

  // ==============================
  // 32-bit word operations
  // ==============================
  always_comb begin
    case (op.funct3)
      exe_pkg::F3_ADD: res32 = sub ? op.op1[31:0] - op.op2[31:0]
                                   : op.op1[31:0] + op.op2[31:0];
      exe_pkg::F3_SLL: res32 = op.op1[31:0] << shamt_w;
      exe_pkg::F3_SR: begin
        if (op.alt) begin
          res32 = $signed(op.op1[31:0]) >>> shamt_w;
        end else begin
          res32 = op.op1[31:0] >> shamt_w;
        end
      end
      default:         res32 = '0;
    endcase
  end

  always_comb begin
    case (op.op_class)
      exe_pkg::OP,
      exe_pkg::OP_IMM:    o_rd_wdata = res64;
      exe_pkg::OP_32,
      exe_pkg::OP_IMM_32: o_rd_wdata = {{32{res32[31]}}, res32};
      exe_pkg::LUI:       o_rd_wdata = op.op2;
      exe_pkg::AUIPC:     o_rd_wdata = op.pc + op.op2;
      exe_pkg::JAL,
      exe_pkg::JALR:      o_rd_wdata = op.pc + exe_pkg::INST_BYTES;
      default:            o_rd_wdata = '0;
    endcase
  end

  // Memory side.
  assign is_load  = op.op_class == exe_pkg::LOAD;
  assign is_store = op.op_class == exe_pkg::STORE;

  assign o_memren  = is_load;
  assign o_memwen  = is_store;
  assign o_memaddr = (is_load || is_store) ? op.op1 + op.imm : '0;

  assign o_rd_wen = i_rd_wen_req && !is_store && op.op_class != exe_pkg::BRANCH;

  // No access or write-back while the stage is empty.
  a_idle_quiet: assert final (op.ena || !(o_memren || o_memwen || o_rd_wen))
    else $error("ALU active while the stage is empty");

endmodule

// ==== design/exe_branch.sv ====
// Branch evaluation, next-PC resolution and redirect detection.

`timescale 1ns/1ns

module exe_branch (
  exe_op_if.branch        op,
  input  exe_pkg::xlen_t  i_pc_pred,
  output logic            o_pc_jmp,
  output exe_pkg::xlen_t  o_pc_jmpaddr
);

  logic            eq;
  logic            lt;
  logic            ltu;
  logic            taken;
  exe_pkg::xlen_t  pc_seq;
  exe_pkg::xlen_t  pc_next;

  assign eq  = op.op1 == op.op2;
  assign lt  = $signed(op.op1) < $signed(op.op2);
  assign ltu = op.op1 < op.op2;

  always_comb begin
    case (op.funct3)
      exe_pkg::F3_BEQ:  taken = eq;
      exe_pkg::F3_BNE:  taken = !eq;
      exe_pkg::F3_BLT:  taken = lt;
      exe_pkg::F3_BGE:  taken = !lt;
      exe_pkg::F3_BLTU: taken = ltu;
      exe_pkg::F3_BGEU: taken = !ltu;
      default:          taken = 1'b0;
    endcase
  end

  // ==============================
  // Next PC
  // ==============================
  assign pc_seq = op.pc + exe_pkg::INST_BYTES;

  always_comb begin
    case (op.op_class)
      exe_pkg::JAL:    pc_next = op.pc + op.imm;
      exe_pkg::JALR:   pc_next = (op.op1 + op.imm) & ~64'd1;
      exe_pkg::BRANCH: pc_next = taken ? op.pc + op.imm : pc_seq;
      default:         pc_next = pc_seq;
    endcase
  end

  // No redirect while the stage is empty.
  assign o_pc_jmp     = op.ena && (pc_next != i_pc_pred);
  assign o_pc_jmpaddr = o_pc_jmp ? pc_next : '0;

  // Decoder supplies halfword-aligned targets.
  a_jmp_align: assert final (!o_pc_jmp || !o_pc_jmpaddr[0])
    else $error("redirect target has bit 0 set");

endmodule

// ==== design/exe_top.sv ====
// Execute stage top level with the ALU and branch units.

`timescale 1ns/1ns

module exe_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_dec_req,
  output logic                o_dec_ack,
  output logic                o_exe_req,
  input  logic                i_exe_ack,
  input  exe_pkg::op_class_t  i_op_class,
  input  exe_pkg::funct3_t    i_funct3,
  input  logic                i_alt,
  input  exe_pkg::xlen_t      i_pc,
  input  exe_pkg::inst_t      i_inst,
  input  exe_pkg::xlen_t      i_op1,
  input  exe_pkg::xlen_t      i_op2,
  input  exe_pkg::xlen_t      i_imm,
  input  exe_pkg::xlen_t      i_pc_pred,
  input  exe_pkg::reg_idx_t   i_rd,
  input  logic                i_rd_wen,
  output exe_pkg::xlen_t      o_pc,
  output exe_pkg::inst_t      o_inst,
  output exe_pkg::funct3_t    o_funct3,
  output exe_pkg::reg_idx_t   o_rd,
  output logic                o_rd_wen,
  output exe_pkg::xlen_t      o_rd_wdata,
  output exe_pkg::xlen_t      o_memaddr,
  output logic                o_memren,
  output logic                o_memwen,
  output logic                o_pc_jmp,
  output exe_pkg::xlen_t      o_pc_jmpaddr
);

  logic            rd_wen_req;
  exe_pkg::xlen_t  pc_pred;

  exe_op_if op_if ();

  exe_stage stage_i (
    .clk          (clk),
    .rst          (rst),
    .i_dec_req    (i_dec_req),
    .o_dec_ack    (o_dec_ack),
    .o_exe_req    (o_exe_req),
    .i_exe_ack    (i_exe_ack),
    .i_op_class   (i_op_class),
    .i_funct3     (i_funct3),
    .i_alt        (i_alt),
    .i_pc         (i_pc),
    .i_inst       (i_inst),
    .i_op1        (i_op1),
    .i_op2        (i_op2),
    .i_imm        (i_imm),
    .i_pc_pred    (i_pc_pred),
    .i_rd         (i_rd),
    .i_rd_wen     (i_rd_wen),
    .o_pc         (o_pc),
    .o_inst       (o_inst),
    .o_funct3     (o_funct3),
    .o_rd         (o_rd),
    .o_rd_wen_req (rd_wen_req),
    .o_pc_pred    (pc_pred),
    .op           (op_if.stage)
  );

  exe_alu alu_i (
    .op           (op_if.alu),
    .i_rd_wen_req (rd_wen_req),
    .o_rd_wen     (o_rd_wen),
    .o_rd_wdata   (o_rd_wdata),
    .o_memaddr    (o_memaddr),
    .o_memren     (o_memren),
    .o_memwen     (o_memwen)
  );

  exe_branch branch_i (
    .op           (op_if.branch),
    .i_pc_pred    (pc_pred),
    .o_pc_jmp     (o_pc_jmp),
    .o_pc_jmpaddr (o_pc_jmpaddr)
  );

endmodule

// ==== verification/exe_tb.sv ====
// Execute stage testbench with random instructions, reference model,
// compare tasks, timeout and verdict.

`timescale 1ns/1ns

module exe_tb;

  localparam int NUM_INSTR   = 400;
  localparam int CYCLE_LIMIT = NUM_INSTR * 20 + 100;

  typedef struct packed {
    exe_pkg::op_class_t  op_class;
    exe_pkg::funct3_t    funct3;
    logic                alt;
    exe_pkg::xlen_t      pc;
    exe_pkg::inst_t      inst;
    exe_pkg::xlen_t      op1;
    exe_pkg::xlen_t      op2;
    exe_pkg::xlen_t      imm;
    exe_pkg::xlen_t      pc_pred;
    exe_pkg::reg_idx_t   rd;
    logic                rd_wen;
  } instr_t;

  typedef struct packed {
    exe_pkg::xlen_t  rd_wdata;
    exe_pkg::xlen_t  memaddr;
    exe_pkg::xlen_t  pc_jmpaddr;
    logic            rd_wen;
    logic            memren;
    logic            memwen;
    logic            pc_jmp;
  } result_t;

  logic clk = 1'b0;
  logic rst;
  logic i_dec_req;
  logic o_dec_ack;
  logic o_exe_req;
  logic i_exe_ack;
  exe_pkg::op_class_t i_op_class;
  exe_pkg::funct3_t   i_funct3;
  logic               i_alt;
  exe_pkg::xlen_t     i_pc;
  exe_pkg::inst_t     i_inst;
  exe_pkg::xlen_t     i_op1;
  exe_pkg::xlen_t     i_op2;
  exe_pkg::xlen_t     i_imm;
  exe_pkg::xlen_t     i_pc_pred;
  exe_pkg::reg_idx_t  i_rd;
  logic               i_rd_wen;
  exe_pkg::xlen_t     o_pc;
  exe_pkg::inst_t     o_inst;
  exe_pkg::funct3_t   o_funct3;
  exe_pkg::reg_idx_t  o_rd;
  logic               o_rd_wen;
  exe_pkg::xlen_t     o_rd_wdata;
  exe_pkg::xlen_t     o_memaddr;
  logic               o_memren;
  logic               o_memwen;
  logic               o_pc_jmp;
  exe_pkg::xlen_t     o_pc_jmpaddr;

  instr_t          model_q[$];
  instr_t          cur;
  instr_t          exp_instr;
  result_t         exp_res;
  string           tname;
  int              cycles = 0;
  int              n_sent = 0;
  int              n_checked = 0;
  logic            req_due = 1'b0;
  logic            hold_due = 1'b0;
  exe_pkg::xlen_t  snap_pc;
  exe_pkg::xlen_t  snap_wdata;
  exe_pkg::xlen_t  snap_addr;
  exe_pkg::xlen_t  snap_jmpaddr;

  exe_top dut_i (.*);

  always #50 clk = ~clk;

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_xlen(input string name, input exe_pkg::xlen_t exp,
                            input exe_pkg::xlen_t act);
    if (exp !== act) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic check_inst(input string name, input exe_pkg::inst_t exp,
                            input exe_pkg::inst_t act);
    if (exp !== act) begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic check_reg_idx(input string name, input exe_pkg::reg_idx_t exp,
                               input exe_pkg::reg_idx_t act);
    if (exp !== act) begin
      $display("FAIL %s: expected %0d, actual %0d", name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  task automatic check_funct3(input string name, input exe_pkg::funct3_t exp,
                              input exe_pkg::funct3_t act);
    if (exp !== act) begin
      $display("FAIL %s: expected %b, actual %b", name, exp, act);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  // ==============================
  // Reference model
  // ==============================
  function automatic exe_pkg::xlen_t alu64(input exe_pkg::funct3_t f3, input logic sub,
                                           input logic alt, input exe_pkg::xlen_t a,
                                           input exe_pkg::xlen_t b);
    exe_pkg::xlen_t r;
    case (f3)
      exe_pkg::F3_ADD:  r = sub ? a - b : a + b;
      exe_pkg::F3_SLL:  r = a << b[5:0];
      exe_pkg::F3_SLT:  r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      exe_pkg::F3_SLTU: r = (a < b) ? 64'd1 : 64'd0;
      exe_pkg::F3_XOR:  r = a ^ b;
      exe_pkg::F3_SR: begin
        if (alt) r = $signed(a) >>> b[5:0];
        else r = a >> b[5:0];
      end
      exe_pkg::F3_OR:   r = a | b;
      default:          r = a & b;
    endcase
    return r;
  endfunction

  // Word forms work on the low halves and sign-extend.
  function automatic exe_pkg::xlen_t alu32(input exe_pkg::funct3_t f3, input logic sub,
                                           input logic alt, input exe_pkg::xlen_t a,
                                           input exe_pkg::xlen_t b);
    logic [31:0] a32;
    logic [31:0] b32;
    logic [31:0] w;
    a32 = a[31:0];
    b32 = b[31:0];
    case (f3)
      exe_pkg::F3_ADD: w = sub ? a32 - b32 : a32 + b32;
      exe_pkg::F3_SLL: w = a32 << b32[4:0];
      default: begin
        if (alt) w = $signed(a32) >>> b32[4:0];
        else w = a32 >> b32[4:0];
      end
    endcase
    return {{32{w[31]}}, w};
  endfunction

  function automatic exe_pkg::xlen_t next_pc(input instr_t t);
    logic taken;
    case (t.funct3)
      exe_pkg::F3_BEQ:  taken = (t.op1 == t.op2);
      exe_pkg::F3_BNE:  taken = (t.op1 != t.op2);
      exe_pkg::F3_BLT:  taken = ($signed(t.op1) < $signed(t.op2));
      exe_pkg::F3_BGE:  taken = ($signed(t.op1) >= $signed(t.op2));
      exe_pkg::F3_BLTU: taken = (t.op1 < t.op2);
      default:          taken = (t.op1 >= t.op2);
    endcase
    case (t.op_class)
      exe_pkg::JAL:    return t.pc + t.imm;
      exe_pkg::JALR:   return {t.op1[63:1] + t.imm[63:1] + (t.op1[0] & t.imm[0]), 1'b0};
      exe_pkg::BRANCH: return taken ? t.pc + t.imm : t.pc + 64'd4;
      default:         return t.pc + 64'd4;
    endcase
  endfunction

  function automatic result_t exe_ref(input instr_t t);
    result_t r;
    logic sub;
    exe_pkg::xlen_t nxt;
    r = '0;
    sub = t.alt && (t.op_class == exe_pkg::OP || t.op_class == exe_pkg::OP_32);
    case (t.op_class)
      exe_pkg::OP, exe_pkg::OP_IMM:       r.rd_wdata = alu64(t.funct3, sub, t.alt, t.op1, t.op2);
      exe_pkg::OP_32, exe_pkg::OP_IMM_32: r.rd_wdata = alu32(t.funct3, sub, t.alt, t.op1, t.op2);
      exe_pkg::LUI:                       r.rd_wdata = t.op2;
      exe_pkg::AUIPC:                     r.rd_wdata = t.pc + t.op2;
      exe_pkg::JAL, exe_pkg::JALR:        r.rd_wdata = t.pc + 64'd4;
      default:                            r.rd_wdata = '0;
    endcase
    r.rd_wen = t.rd_wen && t.op_class != exe_pkg::BRANCH && t.op_class != exe_pkg::STORE;
    r.memren = (t.op_class == exe_pkg::LOAD);
    r.memwen = (t.op_class == exe_pkg::STORE);
    r.memaddr = (r.memren || r.memwen) ? t.op1 + t.imm : '0;
    nxt = next_pc(t);
    r.pc_jmp = (nxt != t.pc_pred);
    r.pc_jmpaddr = r.pc_jmp ? nxt : '0;
    return r;
  endfunction

  // ==============================
  // Stimulus
  // ==============================
  function automatic instr_t gen_instr();
    instr_t t;
    logic [11:0] r12;
    t.op_class = exe_pkg::op_class_t'($urandom_range(10, 0));
    t.funct3 = $urandom_range(7, 0);
    t.alt = 1'b0;
    case (t.op_class)
      exe_pkg::OP: t.alt = (t.funct3 == exe_pkg::F3_ADD || t.funct3 == exe_pkg::F3_SR) &&
                           $urandom_range(1, 0);
      exe_pkg::OP_IMM: t.alt = (t.funct3 == exe_pkg::F3_SR) && $urandom_range(1, 0);
      exe_pkg::OP_32, exe_pkg::OP_IMM_32: begin
        case ($urandom_range(2, 0))
          0: t.funct3 = exe_pkg::F3_ADD;
          1: t.funct3 = exe_pkg::F3_SLL;
          default: t.funct3 = exe_pkg::F3_SR;
        endcase
        t.alt = (t.funct3 == exe_pkg::F3_SR ||
                 (t.funct3 == exe_pkg::F3_ADD && t.op_class == exe_pkg::OP_32)) &&
                $urandom_range(1, 0);
      end
      exe_pkg::BRANCH: begin
        while (t.funct3 == 3'b010 || t.funct3 == 3'b011) t.funct3 = $urandom_range(7, 0);
      end
      exe_pkg::LOAD, exe_pkg::STORE: t.funct3 = $urandom_range(3, 0);
      default: t.funct3 = 3'b000;
    endcase
    t.pc = {$urandom, $urandom} & ~64'd3;
    t.inst = $urandom;
    t.op1 = {$urandom, $urandom};
    t.op2 = ($urandom_range(3, 0) == 0) ? t.op1 : {$urandom, $urandom};
    r12 = $urandom;
    t.imm = {{52{r12[11]}}, r12};
    // Jump and branch offsets are even.
    if (t.op_class == exe_pkg::JAL || t.op_class == exe_pkg::BRANCH) t.imm[0] = 1'b0;
    if (t.op_class == exe_pkg::OP_IMM || t.op_class == exe_pkg::OP_IMM_32) t.op2 = t.imm;
    t.rd = $urandom;
    t.rd_wen = $urandom;
    t.pc_pred = $urandom_range(1, 0) ? next_pc(t) : ({$urandom, $urandom} & ~64'd3);
    return t;
  endfunction

  task automatic apply_inputs(input instr_t t, input logic req);
    i_dec_req  = req;
    i_op_class = t.op_class;
    i_funct3   = t.funct3;
    i_alt      = t.alt;
    i_pc       = t.pc;
    i_inst     = t.inst;
    i_op1      = t.op1;
    i_op2      = t.op2;
    i_imm      = t.imm;
    i_pc_pred  = t.pc_pred;
    i_rd       = t.rd;
    i_rd_wen   = t.rd_wen;
  endtask

  // Sink, ready about 60 percent of the time.
  always @(negedge clk) begin
    i_exe_ack = ($urandom_range(9, 0) < 6);
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Run timed out after %0d cycles", cycles);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

  // ==============================
  // Compare process
  // ==============================
  always @(negedge clk) begin
    #5;
    if (!rst) begin
      if (req_due) check_flag("req one cycle after capture", 1'b1, o_exe_req);
      if (hold_due) begin
        check_flag("stable req", 1'b1, o_exe_req);
        check_xlen("stable pc", snap_pc, o_pc);
        check_xlen("stable rd_wdata", snap_wdata, o_rd_wdata);
        check_xlen("stable memaddr", snap_addr, o_memaddr);
        check_xlen("stable pc_jmpaddr", snap_jmpaddr, o_pc_jmpaddr);
      end
      req_due = i_dec_req && o_dec_ack && !o_exe_req;
      if (o_exe_req && i_exe_ack) begin
        if (model_q.size() == 0) begin
          $display("Result offered with no instruction pending");
          $display("FAIL: see errors above");
          $fatal(1);
        end
        exp_instr = model_q.pop_front();
        exp_res = exe_ref(exp_instr);
        tname = $sformatf("inst %0d %s", n_checked, exp_instr.op_class.name());
        check_xlen({tname, " pc"}, exp_instr.pc, o_pc);
        check_inst({tname, " inst"}, exp_instr.inst, o_inst);
        check_xlen({tname, " rd_wdata"}, exp_res.rd_wdata, o_rd_wdata);
        check_xlen({tname, " memaddr"}, exp_res.memaddr, o_memaddr);
        check_xlen({tname, " pc_jmpaddr"}, exp_res.pc_jmpaddr, o_pc_jmpaddr);
        check_flag({tname, " rd_wen"}, exp_res.rd_wen, o_rd_wen);
        check_flag({tname, " memren"}, exp_res.memren, o_memren);
        check_flag({tname, " memwen"}, exp_res.memwen, o_memwen);
        check_flag({tname, " pc_jmp"}, exp_res.pc_jmp, o_pc_jmp);
        check_reg_idx({tname, " rd"}, exp_instr.rd, o_rd);
        check_funct3({tname, " funct3"}, exp_instr.funct3, o_funct3);
        n_checked++;
      end
      hold_due = o_exe_req && !i_exe_ack;
      snap_pc = o_pc;
      snap_wdata = o_rd_wdata;
      snap_addr = o_memaddr;
      snap_jmpaddr = o_pc_jmpaddr;
    end
  end

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    void'($urandom(32'h14b61fac));
    rst = 1'b1;
    i_exe_ack = 1'b0;
    apply_inputs('0, 1'b0);
    repeat (2) @(negedge clk);
    rst = 1'b0;
    #5;
    check_flag("reset exe_req", 1'b0, o_exe_req);
    check_flag("reset dec_ack", 1'b1, o_dec_ack);
    check_xlen("reset pc", '0, o_pc);
    check_inst("reset inst", '0, o_inst);
    check_xlen("reset rd_wdata", '0, o_rd_wdata);
    check_xlen("reset memaddr", '0, o_memaddr);
    check_xlen("reset pc_jmpaddr", '0, o_pc_jmpaddr);
    check_flag("reset rd_wen", 1'b0, o_rd_wen);
    check_flag("reset memren", 1'b0, o_memren);
    check_flag("reset memwen", 1'b0, o_memwen);
    check_flag("reset pc_jmp", 1'b0, o_pc_jmp);
    check_reg_idx("reset rd", '0, o_rd);
    check_funct3("reset funct3", '0, o_funct3);

    cur = gen_instr();
    while (n_sent < NUM_INSTR) begin
      @(negedge clk);
      apply_inputs(cur, $urandom_range(3, 0) != 0);
      #5;
      if (i_dec_req && o_dec_ack) begin
        model_q.push_back(cur);
        n_sent++;
        cur = gen_instr();
      end
    end
    @(negedge clk);
    i_dec_req = 1'b0;
    while (n_checked < NUM_INSTR) @(negedge clk);

    // Stage must be empty once the last result has left.
    if (model_q.size() != 0 || o_exe_req) begin
      $display("Stage not drained at the end: %0d queued, exe_req %b",
               model_q.size(), o_exe_req);
      $display("FAIL: see errors above");
      $fatal(1);
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// ==== all.f ====
design/exe_pkg.sv
design/exe_op_if.sv
design/exe_stage.sv
design/exe_alu.sv
design/exe_branch.sv
design/exe_top.sv
verification/exe_tb.sv
